// ==== sim.f ====
+incdir+source
source/agu_pkg.sv
source/agu_cfg_regs.sv
source/agu_core.sv
source/agu_status.sv
source/agu_top.sv
verification/agu_tb.sv

// ==== Makefile ====
# Verilator build and run of the address generator testbench

VERILATOR  ?= verilator
TOP        ?= agu_tb
RTL_TOP    ?= agu_top
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= Test OK

SIM_BIN  = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(wildcard source/*.sv source/*.svh verification/*.sv)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/agu_tb.sv ====
`timescale 1ns/1ns
`include "agu_cfg.svh"

module agu_tb;

   localparam int CLK_PERIOD = 4;
   localparam int RST_CYCLES = 3;
   localparam int DRIVE_DLY  = 1;
   localparam int NUM_RUNS   = 4;
   localparam int MAX_ITER   = 6;
   localparam int MAX_PERIOD = 8;
   localparam int MAX_DELAY  = 3;
   localparam int WATCHDOG_CYCLES =
      NUM_RUNS * (MAX_ITER * MAX_PERIOD + MAX_DELAY + 20) + RST_CYCLES;

   logic                                 clk;
   logic                                 rst;
   logic                                 cfg_we;
   logic [`AGU_CH_W-1:0]                 cfg_ch;
   logic                                 cfg_sel;
   agu_pkg::cfg_word_u                   cfg_data;
   logic                                 init;
   logic                                 run;
   agu_pkg::agu_out_t [`AGU_N_CH-1:0]    ch_out;
   logic [`AGU_N_CH-1:0][`AGU_CNT_W-1:0] acc_cnt;
   logic                                 all_done;
   logic                                 done_pulse;

   integer seed = 32'hd2bc_02cf;
   int     value_errors = 0;
   int     other_errors = 0;

   agu_pkg::agu_cfg_t      host_cfg [`AGU_N_CH];   // as written by the host
   agu_pkg::agu_cfg_t      run_cfg  [`AGU_N_CH];   // latched on the run edge
   logic                   active;
   int                     t_run;                  // cycles since the run edge
   logic [`AGU_N_CH-1:0]   exp_en;
   logic [`AGU_N_CH-1:0]   exp_done;
   logic [`AGU_ADDR_W-1:0] exp_addr [`AGU_N_CH];
   logic [`AGU_CNT_W-1:0]  exp_acc  [`AGU_N_CH];
   logic                   exp_all_done;
   logic                   prev_all_done;
   logic                   exp_pulse;

   agu_top dut0 (
      .clk        (clk),
      .rst        (rst),
      .cfg_we     (cfg_we),
      .cfg_ch     (cfg_ch),
      .cfg_sel    (cfg_sel),
      .cfg_data   (cfg_data),
      .init       (init),
      .run        (run),
      .ch_out     (ch_out),
      .acc_cnt    (acc_cnt),
      .all_done   (all_done),
      .done_pulse (done_pulse)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic int run_length(agu_pkg::timing_t tm);
      return int'(tm.delay) + int'(tm.iterations) * int'(tm.period);
   endfunction

   function automatic int total_accesses(agu_pkg::timing_t tm);
      return int'(tm.iterations) * int'(tm.duty);
   endfunction

   function automatic logic enabled_at(agu_pkg::timing_t tm, int t);
      int rel;
      rel = t - int'(tm.delay);
      if (rel < 0 || t >= run_length(tm))
         return 1'b0;
      return (rel % int'(tm.period)) < int'(tm.duty);
   endfunction

   // start, one incr per enabled cycle, one shift per finished period
   function automatic logic [`AGU_ADDR_W-1:0] address_at(agu_pkg::agu_cfg_t c, int t);
      int rel;
      int k;
      int j;
      int sum;
      rel = t - int'(c.timing.delay);
      if (rel < 0 || c.timing.period == '0)
         return c.addr.start;
      k   = rel / int'(c.timing.period);
      j   = rel % int'(c.timing.period);
      sum = int'(c.addr.start) + (k * int'(c.timing.duty) + j) * int'(c.addr.incr)
            + k * int'(c.addr.shift);
      return sum[`AGU_ADDR_W-1:0];
   endfunction

   always_comb begin
      for (int i = 0; i < `AGU_N_CH; i++) begin
         exp_en[i]   = active && enabled_at(run_cfg[i].timing, t_run);
         exp_done[i] = !(active && t_run < run_length(run_cfg[i].timing));
         exp_addr[i] = address_at(run_cfg[i], t_run);
      end
      exp_all_done = &exp_done;
   end

   always @(posedge clk) begin
      if (rst) begin
         active        <= 1'b0;
         t_run         <= 0;
         prev_all_done <= 1'b1;
         exp_pulse     <= 1'b0;
         for (int i = 0; i < `AGU_N_CH; i++) begin
            run_cfg[i] <= '0;
            exp_acc[i] <= '0;
         end
      end else begin
         if (run) begin
            active  <= 1'b1;
            t_run   <= 0;
            run_cfg <= host_cfg;
         end else if (active) begin
            t_run <= t_run + 1;
         end
         for (int i = 0; i < `AGU_N_CH; i++) begin
            if (init)
               exp_acc[i] <= '0;
            else if (exp_en[i])
               exp_acc[i] <= exp_acc[i] + 1'b1;
         end
         prev_all_done <= exp_all_done;
         exp_pulse     <= exp_all_done && !prev_all_done;
      end
   end

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
      value_errors++;
      $display("Fail %s: got %0h, expected %0h at %0t ns", name, got, want, $time);
   endtask

   task automatic report_failure(input string what);
      other_errors++;
      $display("Error: %s at %0t ns", what, $time);
   endtask

   // outputs are checked mid-cycle, where they are settled
   for (genvar i = 0; i < `AGU_N_CH; i++) begin : g_chk
      a_en: assert property (@(negedge clk) disable iff (rst)
         ch_out[i].mem_en == exp_en[i])
         else report_mismatch($sformatf("ch_out[%0d].mem_en", i),
                              32'(ch_out[i].mem_en), 32'(exp_en[i]));
      a_addr: assert property (@(negedge clk) disable iff (rst)
         ch_out[i].mem_en |-> ch_out[i].addr == exp_addr[i])
         else report_mismatch($sformatf("ch_out[%0d].addr", i),
                              32'(ch_out[i].addr), 32'(exp_addr[i]));
      a_done: assert property (@(negedge clk) disable iff (rst)
         ch_out[i].done == exp_done[i])
         else report_mismatch($sformatf("ch_out[%0d].done", i),
                              32'(ch_out[i].done), 32'(exp_done[i]));
      a_acc: assert property (@(negedge clk) disable iff (rst)
         acc_cnt[i] == exp_acc[i])
         else report_mismatch($sformatf("acc_cnt[%0d]", i),
                              32'(acc_cnt[i]), 32'(exp_acc[i]));
      a_total: assert property (@(negedge clk) disable iff (rst)
         $rose(all_done) |-> int'(acc_cnt[i]) == total_accesses(run_cfg[i].timing))
         else report_mismatch($sformatf("acc_cnt[%0d] at completion", i),
                              32'(acc_cnt[i]), 32'(total_accesses(run_cfg[i].timing)));
   end

   a_all_done: assert property (@(negedge clk) disable iff (rst)
      all_done == exp_all_done)
      else report_mismatch("all_done", 32'(all_done), 32'(exp_all_done));
   a_pulse: assert property (@(negedge clk) disable iff (rst)
      done_pulse == exp_pulse)
      else report_mismatch("done_pulse", 32'(done_pulse), 32'(exp_pulse));
   a_pulse_once: assert property (@(negedge clk) disable iff (rst)
      done_pulse |=> !done_pulse)
      else report_failure("done_pulse stayed high for more than one cycle");

   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_DLY;
      cfg_we = 1'b0;
      init   = 1'b0;
      run    = 1'b0;
   endtask

   task automatic write_word(input int ch, input logic sel, input agu_pkg::cfg_word_u word);
      next_cycle();
      cfg_we   = 1'b1;
      cfg_ch   = ch[`AGU_CH_W-1:0];
      cfg_sel  = sel;
      cfg_data = word;
   endtask

   task automatic random_config(output agu_pkg::agu_cfg_t c);
      int period;
      int duty;
      int iters;
      int delay;
      int rnd;
      period = 1 + int'($unsigned($random(seed)) % MAX_PERIOD);
      duty   = 1 + int'($unsigned($random(seed)) % period);
      iters  = 1 + int'($unsigned($random(seed)) % MAX_ITER);
      delay  = int'($unsigned($random(seed)) % (MAX_DELAY + 1));
      c = '0;
      c.timing.period     = period[`AGU_PERIOD_W-1:0];
      c.timing.duty       = duty[`AGU_PERIOD_W-1:0];
      c.timing.iterations = iters[`AGU_ADDR_W-1:0];
      c.timing.delay      = delay[`AGU_PERIOD_W-1:0];
      rnd = $random(seed);
      c.addr.start = rnd[`AGU_ADDR_W-1:0];
      rnd = $random(seed);
      c.addr.shift = rnd[`AGU_ADDR_W-1:0];
      rnd = $random(seed);
      c.addr.incr  = rnd[`AGU_ADDR_W-1:0];
   endtask

   // same host word, once per union view
   task automatic program_channel(input int ch, input agu_pkg::agu_cfg_t c);
      agu_pkg::cfg_word_u word;
      word        = '0;
      word.timing = c.timing;
      write_word(ch, 1'b0, word);
      word.addr = c.addr;
      write_word(ch, 1'b1, word);
      host_cfg[ch] = c;
   endtask

   task automatic start_run(input int mode);
      next_cycle();
      init = 1'b1;
      if (mode == 1) begin
         run = 1'b1;   // init and run together
      end else begin
         if (mode == 2)
            next_cycle();
         next_cycle();
         run = 1'b1;
      end
   endtask

   task automatic wait_run_done();
      next_cycle();
      do
         @(negedge clk);
      while (!done_pulse);
   endtask

   task automatic close_report();
      $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
   endtask

   initial begin
      agu_pkg::agu_cfg_t c;
      rst      = 1'b1;
      cfg_we   = 1'b0;
      cfg_ch   = '0;
      cfg_sel  = 1'b0;
      cfg_data = '0;
      init     = 1'b0;
      run      = 1'b0;
      for (int i = 0; i < `AGU_N_CH; i++)
         host_cfg[i] = '0;
      repeat (RST_CYCLES) @(posedge clk);
      #DRIVE_DLY;
      rst = 1'b0;
      for (int r = 0; r < NUM_RUNS; r++) begin
         for (int i = 0; i < `AGU_N_CH; i++) begin
            random_config(c);
            program_channel((r % 2 == 0) ? i : `AGU_N_CH - 1 - i, c);  // odd runs reversed
         end
         start_run(r % 3);
         wait_run_done();
      end
      repeat (4) next_cycle();
      close_report();
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      report_failure("watchdog expired before all runs finished");
      close_report();
      $finish;
   end

endmodule

// ==== source/agu_top.sv ====
`timescale 1ns/1ns
`include "agu_cfg.svh"

module agu_top (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  cfg_we,
   input  logic [`AGU_CH_W-1:0]                  cfg_ch,
   input  logic                                  cfg_sel,
   input  agu_pkg::cfg_word_u                    cfg_data,
   input  logic                                  init,
   input  logic                                  run,
   output agu_pkg::agu_out_t [`AGU_N_CH-1:0]     ch_out,
   output logic [`AGU_N_CH-1:0][`AGU_CNT_W-1:0]  acc_cnt,
   output logic                                  all_done,
   output logic                                  done_pulse
);

   agu_pkg::agu_cfg_t [`AGU_N_CH-1:0] cfg;

   agu_cfg_regs u_cfg_regs (
      .clk      (clk),
      .rst      (rst),
      .cfg_we   (cfg_we),
      .cfg_ch   (cfg_ch),
      .cfg_sel  (cfg_sel),
      .cfg_data (cfg_data),
      .cfg      (cfg)
   );

   // one generator per channel, init and run shared
   for (genvar i = 0; i < `AGU_N_CH; i++) begin : g_agu
      agu_core u_core (
         .clk  (clk),
         .rst  (rst),
         .init (init),
         .run  (run),
         .cfg  (cfg[i]),
         .out  (ch_out[i])
      );
   end

   agu_status u_status (
      .clk        (clk),
      .rst        (rst),
      .init       (init),
      .ch         (ch_out),
      .acc_cnt    (acc_cnt),
      .all_done   (all_done),
      .done_pulse (done_pulse)
   );

endmodule

// ==== source/agu_status.sv ====
`timescale 1ns/1ns
`include "agu_cfg.svh"

module agu_status (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  init,
   input  agu_pkg::agu_out_t [`AGU_N_CH-1:0]     ch,
   output logic [`AGU_N_CH-1:0][`AGU_CNT_W-1:0]  acc_cnt,
   output logic                                  all_done,
   output logic                                  done_pulse
);

   logic [`AGU_N_CH-1:0] done_vec;
   logic                 all_done_q;

   always_comb begin
      for (int i = 0; i < `AGU_N_CH; i++)
         done_vec[i] = ch[i].done;
   end

   assign all_done = &done_vec;

   // enabled cycles per channel, stuck at full scale
   always_ff @(posedge clk) begin
      if (rst || init) begin
         acc_cnt <= '0;
      end else begin
         for (int i = 0; i < `AGU_N_CH; i++) begin
            if (ch[i].mem_en && acc_cnt[i] != '1)
               acc_cnt[i] <= acc_cnt[i] + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         all_done_q <= 1'b1;   // no pulse coming out of reset
         done_pulse <= 1'b0;
      end else begin
         all_done_q <= all_done;
         done_pulse <= all_done && !all_done_q;
      end
   end

   a_pulse_single: assert property (@(posedge clk) disable iff (rst)
      done_pulse |=> !done_pulse);

endmodule

// ==== source/agu_core.sv ====
`timescale 1ns/1ns
`include "agu_cfg.svh"

module agu_core (
   input  logic              clk,
   input  logic              rst,
   input  logic              init,
   input  logic              run,
   input  agu_pkg::agu_cfg_t cfg,
   output agu_pkg::agu_out_t out
);

   localparam logic IDLE = 1'b0;
   localparam logic RUN  = 1'b1;

   localparam logic signed [`AGU_PERIOD_W:0] PER_ONE = 1;

   logic                          state;
   logic                          state_nxt;
   logic signed [`AGU_PERIOD_W:0] per_cnt;      // negative while the delay runs
   logic signed [`AGU_PERIOD_W:0] per_cnt_nxt;
   logic [`AGU_ADDR_W-1:0]        iter;         // current period, from 1
   logic [`AGU_ADDR_W-1:0]        iter_nxt;
   agu_pkg::agu_out_t             out_q;
   agu_pkg::agu_out_t             out_nxt;

   logic signed [`AGU_PERIOD_W:0] period_ext;
   logic signed [`AGU_PERIOD_W:0] duty_ext;
   logic signed [`AGU_PERIOD_W:0] delay_ext;
   logic                          period_end;
   logic                          duty_hit;
   logic                          last_iter;
   logic                          gap;          // period has idle cycles

   assign period_ext = $signed({1'b0, cfg.timing.period});
   assign duty_ext   = $signed({1'b0, cfg.timing.duty});
   assign delay_ext  = $signed({1'b0, cfg.timing.delay});

   assign period_end = (per_cnt == period_ext);
   assign duty_hit   = (per_cnt == duty_ext);
   assign last_iter  = (iter == cfg.timing.iterations);
   assign gap        = (cfg.timing.period != cfg.timing.duty);

   always_comb begin
      state_nxt   = state;
      per_cnt_nxt = per_cnt;
      iter_nxt    = iter;
      out_nxt     = out_q;

      if (state == IDLE) begin
         if (init) begin
            per_cnt_nxt  = PER_ONE - delay_ext;
            iter_nxt     = `AGU_ADDR_W'd1;
            out_nxt.addr = cfg.addr.start;
         end
         if (run) begin
            state_nxt    = RUN;
            out_nxt.done = 1'b0;
            if (cfg.timing.delay == '0)
               out_nxt.mem_en = 1'b1;   // no delay, first burst starts at once
         end
      end else begin
         // burst start after the delay or at a new period
         if (per_cnt == '0 || (period_end && !last_iter))
            out_nxt.mem_en = 1'b1;
         if (duty_hit && (gap || last_iter))
            out_nxt.mem_en = 1'b0;

         if (period_end) begin
            per_cnt_nxt = PER_ONE;
            iter_nxt    = iter + 1'b1;
         end else begin
            per_cnt_nxt = per_cnt + PER_ONE;
         end

         // address steps, held on the last cycle of a burst
         if (period_end)
            out_nxt.addr = out_q.addr + cfg.addr.incr + cfg.addr.shift;
         else if (out_q.mem_en && !(duty_hit && gap))
            out_nxt.addr = out_q.addr + cfg.addr.incr;

         if (period_end && last_iter) begin
            state_nxt    = IDLE;
            out_nxt.done = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state        <= IDLE;
         per_cnt      <= '0;
         iter         <= '0;
         out_q.addr   <= '0;
         out_q.mem_en <= 1'b0;
         out_q.done   <= 1'b1;
      end else begin
         state   <= state_nxt;
         per_cnt <= per_cnt_nxt;
         iter    <= iter_nxt;
         out_q   <= out_nxt;
      end
   end

   assign out = out_q;

   a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
      (state == IDLE) |-> !out_q.mem_en);

   // host must keep the timing word sane while a channel runs
   a_duty_range: assert property (@(posedge clk) disable iff (rst)
      (state == RUN) |-> (cfg.timing.duty != '0 && cfg.timing.duty <= cfg.timing.period));

endmodule

// ==== source/agu_cfg_regs.sv ====
`timescale 1ns/1ns
`include "agu_cfg.svh"

module agu_cfg_regs (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  cfg_we,
   input  logic [`AGU_CH_W-1:0]                  cfg_ch,
   input  logic                                  cfg_sel,   // 1 selects the address word
   input  agu_pkg::cfg_word_u                    cfg_data,
   output agu_pkg::agu_cfg_t [`AGU_N_CH-1:0]     cfg
);

   localparam logic SEL_TIMING = 1'b0;
   localparam logic SEL_ADDR   = 1'b1;

   agu_pkg::timing_t      wr_timing;
   agu_pkg::addr_fields_t wr_addr;
   logic                  wr_timing_en;
   logic                  wr_addr_en;

   // both views of the same host word, pad bits dropped
   always_comb begin
      wr_timing     = cfg_data.timing;
      wr_timing.pad = '0;
      wr_addr       = cfg_data.addr;
      wr_addr.pad   = '0;
   end

   assign wr_timing_en = cfg_we && (cfg_sel == SEL_TIMING);
   assign wr_addr_en   = cfg_we && (cfg_sel == SEL_ADDR);

   for (genvar i = 0; i < `AGU_N_CH; i++) begin : g_ch
      agu_pkg::timing_t      timing_q;
      agu_pkg::addr_fields_t addr_q;
      logic                  hit;

      assign hit = (cfg_ch == i);

      always_ff @(posedge clk) begin
         if (rst) begin
            timing_q <= '0;
            addr_q   <= '0;
         end else begin
            if (wr_timing_en && hit)
               timing_q <= wr_timing;
            if (wr_addr_en && hit)
               addr_q <= wr_addr;
         end
      end

      always_comb begin
         cfg[i].timing = timing_q;
         cfg[i].addr   = addr_q;
      end
   end

   // a write to a missing channel would be lost silently
   a_ch_range: assert property (@(posedge clk) disable iff (rst)
      cfg_we |-> (cfg_ch < `AGU_N_CH));

endmodule

// ==== source/agu_pkg.sv ====
`include "agu_cfg.svh"

package agu_pkg;

   // timing view of a configuration word
   typedef struct packed {
      logic [`AGU_TIMING_PAD-1:0] pad;
      logic [`AGU_ADDR_W-1:0]     iterations;
      logic [`AGU_PERIOD_W-1:0]   period;
      logic [`AGU_PERIOD_W-1:0]   duty;    // 1 to period
      logic [`AGU_PERIOD_W-1:0]   delay;
   } timing_t;

   // address view of a configuration word
   typedef struct packed {
      logic [`AGU_ADDR_PAD-1:0]      pad;
      logic [`AGU_ADDR_W-1:0]        start;
      logic signed [`AGU_ADDR_W-1:0] shift;  // extra step at a period boundary
      logic signed [`AGU_ADDR_W-1:0] incr;
   } addr_fields_t;

   // one host word, read as timing or as address fields
   typedef union packed {
      timing_t      timing;
      addr_fields_t addr;
   } cfg_word_u;

   typedef struct packed {
      timing_t      timing;
      addr_fields_t addr;
   } agu_cfg_t;

   typedef struct packed {
      logic [`AGU_ADDR_W-1:0] addr;
      logic                   mem_en;
      logic                   done;
   } agu_out_t;

endpackage

// ==== source/agu_cfg.svh ====
`ifndef AGU_CFG_SVH
`define AGU_CFG_SVH

`define AGU_ADDR_W    10  // address and iteration count
`define AGU_PERIOD_W  5   // period, duty and delay
`define AGU_N_CH      4   // 1 to 8
`define AGU_CNT_W     16

// host side
`define AGU_CH_W      3   // channel index, enough for 8 channels
`define AGU_WORD_W    32

// unused top bits of the two views of a host word
`define AGU_TIMING_PAD (`AGU_WORD_W - `AGU_ADDR_W - 3 * `AGU_PERIOD_W)
`define AGU_ADDR_PAD   (`AGU_WORD_W - 3 * `AGU_ADDR_W)

`endif
